/* common/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    // Opcode byte seen as aaa_bbb_cc fields
    typedef struct packed {
        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;
    } opcode_fields_t;

    typedef union packed {
        logic [7:0]     raw;
        opcode_fields_t f;
    } opcode_t;

    // Time states
    typedef logic [1:0] t_state_t;
    localparam t_state_t T_IDLE = 2'd0;
    localparam t_state_t T_T0   = 2'd1;
    localparam t_state_t T_T1   = 2'd2;

    // Instruction classes
    localparam logic [3:0] CLS_NOP     = 4'd0;
    localparam logic [3:0] CLS_SHIFT   = 4'd1;
    localparam logic [3:0] CLS_INCDEC  = 4'd2;
    localparam logic [3:0] CLS_XFER    = 4'd3;
    localparam logic [3:0] CLS_FLAG    = 4'd4;
    localparam logic [3:0] CLS_ALU_IMM = 4'd5;
    localparam logic [3:0] CLS_LOAD    = 4'd6;
    localparam logic [3:0] CLS_STORE   = 4'd7;

    // SB bus sources
    localparam logic [2:0] SB_NONE = 3'd0;
    localparam logic [2:0] SB_ACC  = 3'd1;
    localparam logic [2:0] SB_X    = 3'd2;
    localparam logic [2:0] SB_Y    = 3'd3;
    localparam logic [2:0] SB_SP   = 3'd4;
    localparam logic [2:0] SB_ALU  = 3'd5;
    localparam logic [2:0] SB_DB   = 3'd6;

    // DB bus sources
    localparam logic [1:0] DB_NONE = 2'd0;
    localparam logic [1:0] DB_DATA = 2'd1;
    localparam logic [1:0] DB_SB   = 2'd2;
    localparam logic [1:0] DB_ONES = 2'd3;

    // ALU inputs and carry-in
    localparam logic [1:0] AIN_NONE   = 2'd0;
    localparam logic [1:0] AIN_SB     = 2'd1;
    localparam logic [1:0] AIN_ZERO   = 2'd2;
    localparam logic [1:0] BIN_NONE   = 2'd0;
    localparam logic [1:0] BIN_DB     = 2'd1;
    localparam logic [1:0] BIN_NOT_DB = 2'd2;
    localparam logic [1:0] CIN_ZERO   = 2'd0;
    localparam logic [1:0] CIN_ONE    = 2'd1;
    localparam logic [1:0] CIN_PSR    = 2'd2;

    // ALU operations
    localparam logic [2:0] ALU_NONE   = 3'd0;
    localparam logic [2:0] ALU_ADD    = 3'd1;
    localparam logic [2:0] ALU_AND    = 3'd2;
    localparam logic [2:0] ALU_OR     = 3'd3;
    localparam logic [2:0] ALU_XOR    = 3'd4;
    localparam logic [2:0] ALU_RSHIFT = 3'd5;

    // Register codes line up with the SB source codes
    localparam logic [2:0] REG_NONE = 3'd0;
    localparam logic [2:0] REG_ACC  = 3'd1;
    localparam logic [2:0] REG_X    = 3'd2;
    localparam logic [2:0] REG_Y    = 3'd3;
    localparam logic [2:0] REG_SP   = 3'd4;

    // Bit positions in the PSR load mask
    localparam int PSR_C = 0;
    localparam int PSR_I = 1;
    localparam int PSR_D = 2;
    localparam int PSR_V = 3;

    typedef struct packed {
        logic [3:0] inst_class;
        logic [2:0] alu_op;
        logic [2:0] src_reg;
        logic [2:0] dst_reg;
        logic       b_invert;
        logic [1:0] carry_in;
        logic       dec_en;
        logic       write_carry;
        logic       write_overflow;
        logic       load_dest;
        logic [3:0] psr_mask;
        logic       psr_value;
        logic       illegal;
    } decoded_inst_t;

    typedef struct packed {
        logic       pc_inc;
        logic       load_abh;
        logic       load_abl;
        logic       adh_from_pch;
        logic       adl_from_pcl;
        logic [2:0] sb_src;
        logic [1:0] db_src;
        logic [1:0] alu_a_src;
        logic [1:0] alu_b_src;
        logic [2:0] alu_op;
        logic [1:0] alu_carry_src;
        logic       alu_dec_en;
        logic       load_alu;
        logic       load_acc;
        logic       load_x;
        logic       load_y;
        logic       load_sp;
        logic       psr_carry_from_alu;
        logic       psr_overflow_from_alu;
        logic       write_zn;
        logic [3:0] psr_load_mask;
        logic       psr_load_value;
        logic       mem_write;
    } ctrl_word_t;

endpackage

/* design/opcode_decode.sv */
`timescale 1ns/1ps

module opcode_decode (
    input  cpu_ctrl_pkg::opcode_t       opcode,
    output cpu_ctrl_pkg::decoded_inst_t inst
);

    function automatic cpu_ctrl_pkg::decoded_inst_t xfer(input logic [2:0] src,
                                                         input logic [2:0] dst);
        cpu_ctrl_pkg::decoded_inst_t d;
        d = '0;
        d.inst_class = cpu_ctrl_pkg::CLS_XFER;
        d.src_reg    = src;
        d.dst_reg    = dst;
        d.load_dest  = 1'b1;
        return d;
    endfunction

    function automatic cpu_ctrl_pkg::decoded_inst_t flag(input int bit_pos, input logic value);
        cpu_ctrl_pkg::decoded_inst_t d;
        d = '0;
        d.inst_class        = cpu_ctrl_pkg::CLS_FLAG;
        d.psr_mask[bit_pos] = 1'b1;
        d.psr_value         = value;
        return d;
    endfunction

    // Compare is a subtract with carry in set and no write-back
    function automatic cpu_ctrl_pkg::decoded_inst_t compare(input logic [2:0] src);
        cpu_ctrl_pkg::decoded_inst_t d;
        d = '0;
        d.inst_class  = cpu_ctrl_pkg::CLS_ALU_IMM;
        d.alu_op      = cpu_ctrl_pkg::ALU_ADD;
        d.src_reg     = src;
        d.b_invert    = 1'b1;
        d.carry_in    = cpu_ctrl_pkg::CIN_ONE;
        d.write_carry = 1'b1;
        return d;
    endfunction

    always_comb begin
        inst = '0;
        case (opcode.raw)
            8'h0A, 8'h2A, 8'h6A, 8'h4A: begin
                inst.inst_class  = cpu_ctrl_pkg::CLS_SHIFT;
                inst.src_reg     = cpu_ctrl_pkg::REG_ACC;
                inst.dst_reg     = cpu_ctrl_pkg::REG_ACC;
                inst.load_dest   = 1'b1;
                inst.write_carry = 1'b1;
                // aaa[1] picks right shift, aaa[0] picks rotate
                inst.alu_op   = opcode.f.aaa[1] ? cpu_ctrl_pkg::ALU_RSHIFT : cpu_ctrl_pkg::ALU_ADD;
                inst.carry_in = opcode.f.aaa[0] ? cpu_ctrl_pkg::CIN_PSR : cpu_ctrl_pkg::CIN_ZERO;
            end
            8'hE8, 8'hC8, 8'hCA, 8'h88: begin
                inst.inst_class = cpu_ctrl_pkg::CLS_INCDEC;
                inst.alu_op     = cpu_ctrl_pkg::ALU_ADD;
                inst.load_dest  = 1'b1;
                inst.src_reg    = (opcode.raw == 8'hE8 || opcode.raw == 8'hCA) ?
                                  cpu_ctrl_pkg::REG_X : cpu_ctrl_pkg::REG_Y;
                inst.dst_reg    = inst.src_reg;
                // Carry one marks an increment
                inst.carry_in   = (opcode.raw == 8'hE8 || opcode.raw == 8'hC8) ?
                                  cpu_ctrl_pkg::CIN_ONE : cpu_ctrl_pkg::CIN_ZERO;
            end
            8'hAA: inst = xfer(cpu_ctrl_pkg::REG_ACC, cpu_ctrl_pkg::REG_X);
            8'hA8: inst = xfer(cpu_ctrl_pkg::REG_ACC, cpu_ctrl_pkg::REG_Y);
            8'hBA: inst = xfer(cpu_ctrl_pkg::REG_SP, cpu_ctrl_pkg::REG_X);
            8'h8A: inst = xfer(cpu_ctrl_pkg::REG_X, cpu_ctrl_pkg::REG_ACC);
            8'h9A: inst = xfer(cpu_ctrl_pkg::REG_X, cpu_ctrl_pkg::REG_SP);
            8'h98: inst = xfer(cpu_ctrl_pkg::REG_Y, cpu_ctrl_pkg::REG_ACC);
            8'h38: inst = flag(cpu_ctrl_pkg::PSR_C, 1'b1);
            8'hF8: inst = flag(cpu_ctrl_pkg::PSR_D, 1'b1);
            8'h78: inst = flag(cpu_ctrl_pkg::PSR_I, 1'b1);
            8'h18: inst = flag(cpu_ctrl_pkg::PSR_C, 1'b0);
            8'hD8: inst = flag(cpu_ctrl_pkg::PSR_D, 1'b0);
            8'h58: inst = flag(cpu_ctrl_pkg::PSR_I, 1'b0);
            8'hB8: inst = flag(cpu_ctrl_pkg::PSR_V, 1'b0);
            8'hEA: inst.inst_class = cpu_ctrl_pkg::CLS_NOP;
            8'hA2, 8'hA0: begin
                inst.inst_class = cpu_ctrl_pkg::CLS_LOAD;
                inst.dst_reg    = opcode.f.cc[1] ? cpu_ctrl_pkg::REG_X : cpu_ctrl_pkg::REG_Y;
                inst.load_dest  = 1'b1;
            end
            default: begin
                if (opcode.f.cc == 2'b01 && opcode.f.bbb == 3'b010 && opcode.f.aaa != 3'b100) begin
                    inst.inst_class = cpu_ctrl_pkg::CLS_ALU_IMM;
                    inst.src_reg    = cpu_ctrl_pkg::REG_ACC;
                    inst.dst_reg    = cpu_ctrl_pkg::REG_ACC;
                    inst.load_dest  = 1'b1;
                    case (opcode.f.aaa)
                        3'b000: inst.alu_op = cpu_ctrl_pkg::ALU_OR;
                        3'b001: inst.alu_op = cpu_ctrl_pkg::ALU_AND;
                        3'b010: inst.alu_op = cpu_ctrl_pkg::ALU_XOR;
                        3'b101: inst.inst_class = cpu_ctrl_pkg::CLS_LOAD;
                        3'b110: inst = compare(cpu_ctrl_pkg::REG_ACC);
                        default: begin
                            // ADC and SBC, aaa[2] marks the subtract
                            inst.alu_op         = cpu_ctrl_pkg::ALU_ADD;
                            inst.b_invert       = opcode.f.aaa[2];
                            inst.carry_in       = cpu_ctrl_pkg::CIN_PSR;
                            inst.dec_en         = 1'b1;
                            inst.write_carry    = 1'b1;
                            inst.write_overflow = 1'b1;
                        end
                    endcase
                end else if (opcode.f.cc == 2'b00 && opcode.f.bbb == 3'b000 &&
                             opcode.f.aaa[2:1] == 2'b11) begin
                    // CPX at E0, CPY at C0
                    inst = compare(opcode.f.aaa[0] ? cpu_ctrl_pkg::REG_X : cpu_ctrl_pkg::REG_Y);
                end else if (opcode.f.cc != 2'b11 && opcode.f.bbb == 3'b001 &&
                             opcode.f.aaa == 3'b100) begin
                    inst.inst_class = cpu_ctrl_pkg::CLS_STORE;
                    case (opcode.f.cc)
                        2'b01:   inst.src_reg = cpu_ctrl_pkg::REG_ACC;
                        2'b10:   inst.src_reg = cpu_ctrl_pkg::REG_X;
                        default: inst.src_reg = cpu_ctrl_pkg::REG_Y;
                    endcase
                end else begin
                    inst.illegal = 1'b1;
                end
            end
        endcase
    end

endmodule

/* design/micro_sequencer.sv */
`timescale 1ns/1ps

module micro_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        opcode_valid,
    input  cpu_ctrl_pkg::decoded_inst_t inst,
    output cpu_ctrl_pkg::decoded_inst_t inst_q,
    output cpu_ctrl_pkg::t_state_t      t_state,
    output logic                        busy
);

    logic accept;

    // New opcode may land while the previous one is in T1
    assign accept = opcode_valid && (t_state != cpu_ctrl_pkg::T_T0);
    assign busy   = (t_state == cpu_ctrl_pkg::T_T0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            t_state <= cpu_ctrl_pkg::T_IDLE;
            inst_q  <= '0;
        end else begin
            if (accept) begin
                t_state <= cpu_ctrl_pkg::T_T0;
                inst_q  <= inst;
            end else if (t_state == cpu_ctrl_pkg::T_T0) begin
                t_state <= cpu_ctrl_pkg::T_T1;
            end else begin
                t_state <= cpu_ctrl_pkg::T_IDLE;
            end
        end
    end

    // Busy T0 always lasts exactly one cycle
    a_busy_then_t1: assert property (@(posedge clk) disable iff (!rst_n)
        busy |=> t_state == cpu_ctrl_pkg::T_T1);

    // T1 is only reached through T0
    a_no_idle_to_t1: assert property (@(posedge clk) disable iff (!rst_n)
        t_state == cpu_ctrl_pkg::T_IDLE |=> t_state != cpu_ctrl_pkg::T_T1);

endmodule

/* design/control_word_gen.sv */
`timescale 1ns/1ps

module control_word_gen (
    input  cpu_ctrl_pkg::decoded_inst_t inst,
    input  cpu_ctrl_pkg::t_state_t      t_state,
    output cpu_ctrl_pkg::ctrl_word_t    ctrl,
    output logic                        illegal
);

    logic fetch;

    function automatic cpu_ctrl_pkg::ctrl_word_t load_reg(input cpu_ctrl_pkg::ctrl_word_t cw,
                                                          input logic [2:0] r);
        cpu_ctrl_pkg::ctrl_word_t c;
        c = cw;
        case (r)
            cpu_ctrl_pkg::REG_ACC: c.load_acc = 1'b1;
            cpu_ctrl_pkg::REG_X:   c.load_x   = 1'b1;
            cpu_ctrl_pkg::REG_Y:   c.load_y   = 1'b1;
            cpu_ctrl_pkg::REG_SP:  c.load_sp  = 1'b1;
            default: ;
        endcase
        return c;
    endfunction

    // Immediate operands fetch their byte in T0 as well as T1
    assign fetch = (t_state == cpu_ctrl_pkg::T_T1) ||
                   (t_state == cpu_ctrl_pkg::T_T0 &&
                    (inst.inst_class == cpu_ctrl_pkg::CLS_ALU_IMM ||
                     inst.inst_class == cpu_ctrl_pkg::CLS_LOAD));

    assign illegal = inst.illegal && (t_state == cpu_ctrl_pkg::T_T0);

    always_comb begin
        ctrl = '0;
        if (t_state == cpu_ctrl_pkg::T_T0) begin
            case (inst.inst_class)
                cpu_ctrl_pkg::CLS_SHIFT, cpu_ctrl_pkg::CLS_INCDEC: begin
                    ctrl.sb_src             = inst.src_reg;
                    ctrl.db_src             = cpu_ctrl_pkg::DB_SB;
                    ctrl.alu_a_src          = cpu_ctrl_pkg::AIN_SB;
                    ctrl.alu_b_src          = cpu_ctrl_pkg::BIN_DB;
                    ctrl.alu_op             = inst.alu_op;
                    ctrl.alu_carry_src      = inst.carry_in;
                    ctrl.load_alu           = 1'b1;
                    ctrl.psr_carry_from_alu = inst.write_carry;
                    if (inst.alu_op == cpu_ctrl_pkg::ALU_RSHIFT) begin
                        // Right shift works on input A alone
                        ctrl.db_src    = cpu_ctrl_pkg::DB_NONE;
                        ctrl.alu_b_src = cpu_ctrl_pkg::BIN_NONE;
                    end else if (inst.inst_class == cpu_ctrl_pkg::CLS_INCDEC) begin
                        if (inst.carry_in == cpu_ctrl_pkg::CIN_ONE) begin
                            // 0 + reg + 1
                            ctrl.alu_a_src = cpu_ctrl_pkg::AIN_ZERO;
                        end else begin
                            // reg + FF
                            ctrl.db_src = cpu_ctrl_pkg::DB_ONES;
                        end
                    end
                end
                cpu_ctrl_pkg::CLS_XFER: begin
                    ctrl.sb_src = inst.src_reg;
                    if (inst.load_dest) begin
                        ctrl = load_reg(ctrl, inst.dst_reg);
                    end
                end
                cpu_ctrl_pkg::CLS_FLAG: begin
                    ctrl.psr_load_mask  = inst.psr_mask;
                    ctrl.psr_load_value = inst.psr_value;
                end
                cpu_ctrl_pkg::CLS_ALU_IMM: begin
                    ctrl.db_src                = cpu_ctrl_pkg::DB_DATA;
                    ctrl.sb_src                = inst.src_reg;
                    ctrl.alu_a_src             = cpu_ctrl_pkg::AIN_SB;
                    ctrl.alu_b_src             = inst.b_invert ? cpu_ctrl_pkg::BIN_NOT_DB :
                                                                 cpu_ctrl_pkg::BIN_DB;
                    ctrl.alu_op                = inst.alu_op;
                    ctrl.alu_carry_src         = inst.carry_in;
                    ctrl.alu_dec_en            = inst.dec_en;
                    ctrl.load_alu              = 1'b1;
                    ctrl.psr_carry_from_alu    = inst.write_carry;
                    ctrl.psr_overflow_from_alu = inst.write_overflow;
                end
                cpu_ctrl_pkg::CLS_LOAD: begin
                    ctrl.db_src   = cpu_ctrl_pkg::DB_DATA;
                    ctrl.sb_src   = cpu_ctrl_pkg::SB_DB;
                    ctrl.write_zn = 1'b1;
                    ctrl          = load_reg(ctrl, inst.dst_reg);
                end
                cpu_ctrl_pkg::CLS_STORE: begin
                    // Source register drives the data bus for the write
                    ctrl.sb_src    = inst.src_reg;
                    ctrl.db_src    = cpu_ctrl_pkg::DB_SB;
                    ctrl.mem_write = 1'b1;
                end
                default: ;
            endcase
        end else if (t_state == cpu_ctrl_pkg::T_T1) begin
            if (inst.inst_class == cpu_ctrl_pkg::CLS_SHIFT ||
                inst.inst_class == cpu_ctrl_pkg::CLS_INCDEC ||
                inst.inst_class == cpu_ctrl_pkg::CLS_ALU_IMM) begin
                ctrl.sb_src = cpu_ctrl_pkg::SB_ALU;
                if (inst.load_dest) begin
                    ctrl = load_reg(ctrl, inst.dst_reg);
                end
                if (inst.inst_class == cpu_ctrl_pkg::CLS_ALU_IMM) begin
                    ctrl.db_src   = cpu_ctrl_pkg::DB_SB;
                    ctrl.write_zn = 1'b1;
                end
            end
        end
        if (fetch) begin
            ctrl.pc_inc       = 1'b1;
            ctrl.adh_from_pch = 1'b1;
            ctrl.load_abh     = 1'b1;
            ctrl.adl_from_pcl = 1'b1;
            ctrl.load_abl     = 1'b1;
        end
    end

    // A store cycle must not also write a register
    a_store_no_load: assert final (!(ctrl.mem_write &&
                                     (ctrl.load_acc || ctrl.load_x ||
                                      ctrl.load_y || ctrl.load_sp)));

endmodule

/* design/microcode_control.sv */
`timescale 1ns/1ps

module microcode_control (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     opcode_valid,
    input  cpu_ctrl_pkg::opcode_t    opcode,
    output cpu_ctrl_pkg::ctrl_word_t ctrl,
    output cpu_ctrl_pkg::t_state_t   t_state,
    output logic                     busy,
    output logic                     illegal
);

    cpu_ctrl_pkg::decoded_inst_t inst;
    cpu_ctrl_pkg::decoded_inst_t inst_q;

    opcode_decode opcode_decode_inst (
        .opcode (opcode),
        .inst   (inst)
    );

    micro_sequencer micro_sequencer_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .opcode_valid (opcode_valid),
        .inst         (inst),
        .inst_q       (inst_q),
        .t_state      (t_state),
        .busy         (busy)
    );

    control_word_gen control_word_gen_inst (
        .inst    (inst_q),
        .t_state (t_state),
        .ctrl    (ctrl),
        .illegal (illegal)
    );

endmodule

/* sim/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_ctrl_pkg::ctrl_word_t ctrl,
    input  cpu_ctrl_pkg::t_state_t   t_state,
    input  logic                     busy,
    input  logic                     illegal,
    output int                       tests_done,
    output int                       tests_failed,
    output int                       other_errors
);

    string       names[$];
    int          gaps[$];
    logic [33:0] t0_words[$];
    logic [33:0] t1_words[$];
    logic        ill_bits[$];
    int          idx;
    int          idle_run;
    logic        pending;
    logic        test_bad;

    initial begin : load_trace
        int          fd;
        int          n;
        int          gap;
        int          ill;
        string       line;
        string       name;
        logic [7:0]  op;
        logic [33:0] w0;
        logic [33:0] w1;
        fd = $fopen("sim/microcode_trace.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %h %d %h %h %d", name, op, gap, w0, w1, ill);
                if (n == 6) begin
                    names.push_back(name);
                    gaps.push_back(gap);
                    t0_words.push_back(w0);
                    t1_words.push_back(w1);
                    ill_bits.push_back(ill != 0);
                end
            end
            $fclose(fd);
        end
    end

    task automatic compare_value(input string what, input logic [33:0] exp,
                                 input logic [33:0] act);
        if (act !== exp) begin
            $display("mismatch %s %s expected %09h actual %09h", names[idx], what, exp, act);
            test_bad = 1'b1;
        end
    endtask

    task automatic check_t0();
        if (idx >= names.size()) begin
            $display("T0 seen at %0t after the last test of the trace", $time);
            other_errors++;
        end else begin
            test_bad = 1'b0;
            // Idle count is only defined once a previous test has ended
            if (idx > 0 && idle_run != gaps[idx]) begin
                $display("test %s started after %0d idle cycles instead of %0d",
                         names[idx], idle_run, gaps[idx]);
                test_bad = 1'b1;
            end
            if (busy !== 1'b1) begin
                $display("test %s: busy was not high during T0", names[idx]);
                test_bad = 1'b1;
            end
            compare_value("t0_ctrl", t0_words[idx], ctrl);
            compare_value("t0_illegal", {33'b0, ill_bits[idx]}, {33'b0, illegal});
            pending = 1'b1;
        end
    endtask

    task automatic check_t1();
        if (t_state !== cpu_ctrl_pkg::T_T1) begin
            $display("test %s: state %0d followed T0 instead of T1", names[idx], t_state);
            test_bad = 1'b1;
        end else begin
            compare_value("t1_ctrl", t1_words[idx], ctrl);
            compare_value("t1_illegal", '0, {33'b0, illegal});
            if (busy !== 1'b0) begin
                $display("test %s: busy stayed high in T1", names[idx]);
                test_bad = 1'b1;
            end
        end
        if (test_bad) begin
            tests_failed++;
            $display("test %s fail", names[idx]);
        end else begin
            $display("test %s pass", names[idx]);
        end
        tests_done++;
        idx++;
        pending  = 1'b0;
        idle_run = 0;
    endtask

    task automatic check_idle();
        if (ctrl !== '0 || illegal !== 1'b0 || busy !== 1'b0) begin
            $display("idle cycle at %0t is not quiet: ctrl %09h illegal %0b busy %0b",
                     $time, ctrl, illegal, busy);
            other_errors++;
        end
        idle_run++;
    endtask

    // Sampled mid-cycle, well clear of edge and input changes
    always @(negedge clk) begin
        if (!rst_n) begin
            idx          = 0;
            idle_run     = 0;
            pending      = 1'b0;
            tests_done   = 0;
            tests_failed = 0;
            other_errors = 0;
        end else if (pending) begin
            check_t1();
        end else if (t_state === cpu_ctrl_pkg::T_T0) begin
            check_t0();
        end else if (t_state === cpu_ctrl_pkg::T_IDLE) begin
            check_idle();
        end else begin
            $display("state %0d at %0t without a T0 before it", t_state, $time);
            other_errors++;
        end
    end

endmodule

/* sim/tb_microcode_control.sv */
`timescale 1ns/1ps

module tb_microcode_control;

    logic                     clk;
    logic                     rst_n;
    logic                     opcode_valid;
    cpu_ctrl_pkg::opcode_t    opcode;
    cpu_ctrl_pkg::ctrl_word_t ctrl;
    cpu_ctrl_pkg::t_state_t   t_state;
    logic                     busy;
    logic                     illegal;

    logic [7:0]  opcodes[$];
    int          gaps[$];
    logic        loaded;
    int          cycle_limit;
    int          cycles;
    logic [31:0] rand_state;
    int          tests_done;
    int          tests_failed;
    int          other_errors;

    microcode_control microcode_control_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .opcode_valid (opcode_valid),
        .opcode       (opcode),
        .ctrl         (ctrl),
        .t_state      (t_state),
        .busy         (busy),
        .illegal      (illegal)
    );

    tb_checker checker_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .t_state      (t_state),
        .busy         (busy),
        .illegal      (illegal),
        .tests_done   (tests_done),
        .tests_failed (tests_failed),
        .other_errors (other_errors)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Entered 10 ns after a rising edge
    // Gap 0 lands the strobe in the T1 cycle of the previous opcode
    task automatic send_opcode(input logic [7:0] op, input int gap);
        repeat (gap) @(posedge clk);
        if (gap > 0) begin
            #10;
        end
        opcode_valid = 1'b1;
        opcode.raw   = op;
        @(posedge clk);
        #10;
        // Sequencer sits in T0 here, so a strobe now must be dropped
        rand_state   = next_random(rand_state);
        opcode_valid = rand_state[16];
        opcode.raw   = rand_state[31:24];
        @(posedge clk);
        #10;
        opcode_valid = 1'b0;
    endtask

    initial begin : main
        int          fd;
        int          n;
        int          gap;
        int          ill;
        string       line;
        string       name;
        logic [7:0]  op;
        logic [33:0] w0;
        logic [33:0] w1;
        rst_n        = 1'b0;
        opcode_valid = 1'b0;
        opcode       = '0;
        rand_state   = 32'hdb04_df94;
        loaded       = 1'b0;
        fd = $fopen("sim/microcode_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/microcode_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %h %d %h %h %d", name, op, gap, w0, w1, ill);
                if (n == 6) begin
                    opcodes.push_back(op);
                    gaps.push_back(gap);
                end
            end
            $fclose(fd);
        end
        cycle_limit = opcodes.size() * 8 + 50;
        loaded      = 1'b1;
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;
        foreach (opcodes[i]) begin
            send_opcode(opcodes[i], gaps[i]);
        end
        // Let the trailing idle words be checked
        repeat (4) @(posedge clk);
        if (tests_done != opcodes.size() || opcodes.size() == 0) begin
            $display("only %0d of %0d tests in the trace were seen",
                     tests_done, opcodes.size());
        end
        $display("%0d tests run, %0d passed, %0d failed, %0d other errors",
                 tests_done, tests_done - tests_failed, tests_failed, other_errors);
        if (opcodes.size() == 0 || tests_done != opcodes.size() ||
            tests_failed != 0 || other_errors != 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end

    initial begin : watchdog
        cycles = 0;
        wait (loaded);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run did not end within %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* sim/microcode_trace.txt */
# name opcode gap t0_word t1_word illegal
# opcode and both 34-bit words in hex, gap and illegal in decimal
asl_a      0A 2 006522100 3f4001000 0
rol_a      2A 0 006532100 3f4001000 0
lsr_a      4A 1 0044a2100 3f4001000 0
ror_a      6A 0 0044b2100 3f4001000 0
inx        E8 0 00a92a000 3f4000800 0
iny        C8 2 00e92a000 3f4000400 0
dex        CA 0 00b522000 3f4000800 0
dey        88 1 00f522000 3f4000400 0
tax        AA 0 004000800 3e0000000 0
tay        A8 0 004000400 3e0000000 0
tsx        BA 3 010000800 3e0000000 0
txa        8A 0 008001000 3e0000000 0
txs        9A 1 008000200 3e0000000 0
tya        98 0 00c001000 3e0000000 0
nop        EA 0 000000000 3e0000000 0
sec        38 2 000000006 3e0000000 0
sed        F8 0 000000012 3e0000000 0
sei        78 0 00000000a 3e0000000 0
clc        18 1 000000004 3e0000000 0
cld        D8 0 000000010 3e0000000 0
cli        58 0 000000008 3e0000000 0
clv        B8 0 000000020 3e0000000 0
ora_imm    09 1 3e5562000 3f6001040 0
and_imm    29 0 3e5542000 3f6001040 0
eor_imm    49 0 3e5582000 3f6001040 0
adc_imm    69 2 3e5536180 3f6001040 0
sbc_imm    E9 0 3e5636180 3f6001040 0
cmp_imm    C9 0 3e562a100 3f6000040 0
cpx_imm    E0 1 3e962a100 3f6000040 0
cpy_imm    C0 0 3ed62a100 3f6000040 0
lda_imm    A9 0 3f9001040 3e0000000 0
ldx_imm    A2 2 3f9000840 3e0000000 0
ldy_imm    A0 0 3f9000440 3e0000000 0
sta_zp     85 0 006000001 3e0000000 0
stx_zp     86 1 00a000001 3e0000000 0
sty_zp     84 0 00e000001 3e0000000 0
illegal_89 89 0 000000000 3e0000000 1
illegal_ff FF 2 000000000 3e0000000 1

/* files.f */
common/cpu_ctrl_pkg.sv
design/opcode_decode.sv
design/micro_sequencer.sv
design/control_word_gen.sv
design/microcode_control.sv
sim/tb_checker.sv
sim/tb_microcode_control.sv

/* Bender.yml */
package:
  name: microcode_control

sources:
  - common/cpu_ctrl_pkg.sv
  - design/opcode_decode.sv
  - design/micro_sequencer.sv
  - design/control_word_gen.sv
  - design/microcode_control.sv
  - target: simulation
    files:
      - sim/tb_checker.sv
      - sim/tb_microcode_control.sv
